//--- common/lsu_macros.svh
/*
  Load/store unit parameters. Depth of the outstanding counter, the
  address width and the fixed protected region of the data side
*/
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Bus transactions that may be granted and still wait for rvalid
`define LSU_DEPTH 2

// Width of data-side byte addresses
`define LSU_ADDR_W 32

// Protected region as inclusive byte bounds on word boundaries
// Any word address from LO to HI faults
`define MPU_PROT_LO 32'h0000_0100
`define MPU_PROT_HI 32'h0000_013c

`endif

//--- common/lsu_pkg.sv
/*
  Load/store unit types. Access kinds issued by the execute stage, the
  result of the protection check and the execute-stage control bits
*/
`default_nettype none

package lsu_pkg;

  // Access kinds, loads first and stores after them
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // Outcome of the protection check on one bus-level address
  typedef enum logic {
    MPU_OK,
    MPU_FAULT
  } mpu_status_e;

  // Execute-stage controls as seen by the unit
  typedef struct packed {
    logic halt_ex;
    logic kill_ex;
  } ctrl_fsm_t;

endpackage

`default_nettype wire

//--- common/obi_if.sv
/*
  OBI-style data bus bundle. Carries the req/gnt address phase and the
  rvalid response phase between the load/store unit and the memory side
*/
`default_nettype none

interface obi_if;
  import obi_pkg::*;

  // Address phase
  logic     req;
  logic     gnt;
  obi_req_t req_payload;

  // Response phase
  logic     rvalid;
  obi_rsp_t rsp_payload;

  // The unit raises req and holds the payload until gnt
  modport manager (
    output req,
    output req_payload,
    input  gnt,
    input  rvalid,
    input  rsp_payload
  );

  // Memory side grants and answers in order
  modport subordinate (
    input  req,
    input  req_payload,
    output gnt,
    output rvalid,
    output rsp_payload
  );

  // Passive view for checkers
  modport monitor (
    input req,
    input req_payload,
    input gnt,
    input rvalid,
    input rsp_payload
  );

endinterface

`default_nettype wire

//--- common/obi_pkg.sv
/*
  Data bus types. The address-phase payload that travels with req and
  the response payload that travels with rvalid
*/
`default_nettype none

package obi_pkg;

  // Address phase, held stable from req until gnt
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } obi_req_t;

  // Response phase, one beat per granted request
  typedef struct packed {
    logic [31:0] rdata;
  } obi_rsp_t;

endpackage

`default_nettype wire

//--- dv/obi_mem_slave.sv
/*
  Data bus memory model for simulation. A word-wide array behind a
  req/gnt/rvalid handshake, with a random grant delay of 0 to 3 cycles
  and a random response delay of 1 to 3 cycles, answered in order
*/
`default_nettype none

module obi_mem_slave (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req,
  input  logic [31:0] addr,
  input  logic        we,
  input  logic [3:0]  be,
  input  logic [31:0] wdata,
  output logic        gnt,
  output logic        rvalid,
  output logic [31:0] rdata
);

  // 512 bytes of storage, upper address bits wrap
  logic [31:0] mem [128];
  // Read data and the cycle from which each beat may be returned
  logic [31:0] rsp_data_q [$];
  int          rsp_due_q [$];
  int          cyc;
  int          wait_left;
  logic        waiting;

  initial begin
    logic [31:0] wa;
    gnt       = 1'b0;
    rvalid    = 1'b0;
    rdata     = 32'h0000_0000;
    cyc       = 0;
    wait_left = 0;
    waiting   = 1'b0;
    // Every word gets a value tied to its own byte address
    for (int i = 0; i < 128; i++) begin
      wa     = i * 4;
      mem[i] = {wa[15:0] ^ 16'ha5c3, ~wa[15:0]};
    end
    forever begin
      // Handshake is judged mid-cycle where req, gnt and payload are settled
      @(negedge clk);
      if (!rst_n) begin
        rsp_data_q.delete();
        rsp_due_q.delete();
        waiting = 1'b0;
      end else if (req && gnt) begin
        if (we) begin
          for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
              mem[addr[8:2]][8*b +: 8] = wdata[8*b +: 8];
            end
          end
          rsp_data_q.push_back(32'h0000_0000);
        end else begin
          rsp_data_q.push_back(mem[addr[8:2]]);
        end
        // Earliest beat is the cycle right after the grant edge
        rsp_due_q.push_back(cyc + 1 + $urandom_range(0, 2));
        waiting = 1'b0;
      end

      @(posedge clk);
      cyc++;
      #2;

      // A fresh request draws its own grant delay
      gnt = 1'b0;
      if (rst_n && req) begin
        if (!waiting) begin
          waiting   = 1'b1;
          wait_left = $urandom_range(0, 3);
        end
        if (wait_left == 0) begin
          gnt = 1'b1;
        end else begin
          wait_left--;
        end
      end

      // Only the oldest beat may go out, which keeps responses in order
      rvalid = 1'b0;
      rdata  = 32'h0000_0000;
      if (rst_n && rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
        rvalid = 1'b1;
        rdata  = rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_lsu.sv
/*
  Testbench for the load/store subsystem. Drives directed and random
  loads and stores from a fixed seed, mirrors them in a shadow byte
  memory and checks every bus request and every core response against
  the expected values, in order
*/
`default_nettype none

`include "lsu_macros.svh"

module tb_lsu;
  import lsu_pkg::*;

  localparam int N_ACCESS   = 400;
  localparam int MAX_CYCLES = N_ACCESS * 20;

  logic        clk;
  logic        rst_n;
  logic        valid;
  lsu_op_e     op;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        halt_ex;
  logic        kill_ex;
  logic        ready;
  logic        busy;
  logic        resp_valid;
  logic [31:0] resp_rdata;
  logic        resp_err;
  logic        obi_req;
  logic        obi_gnt;
  logic [31:0] obi_addr;
  logic        obi_we;
  logic [3:0]  obi_be;
  logic [31:0] obi_wdata;
  logic        obi_rvalid;
  logic [31:0] obi_rdata;

  // Shadow of the bus memory, byte addressed and wrapping like it
  logic [7:0]  shadow [512];
  // Expected bus requests in grant order
  logic [31:0] exp_addr [$];
  logic        exp_we [$];
  logic [3:0]  exp_be [$];
  logic [31:0] exp_wdata [$];
  // Expected core responses in issue order
  logic [31:0] exp_rdata [$];
  logic        exp_err [$];
  int          accepted;
  // Accesses taken by the unit whose core response has not been seen yet
  int          open_accesses;
  int          in_flight;
  int          cycles;

  lsu_subsys DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid      (valid),
    .op         (op),
    .addr       (addr),
    .wdata      (wdata),
    .halt_ex    (halt_ex),
    .kill_ex    (kill_ex),
    .ready      (ready),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .obi_req    (obi_req),
    .obi_gnt    (obi_gnt),
    .obi_addr   (obi_addr),
    .obi_we     (obi_we),
    .obi_be     (obi_be),
    .obi_wdata  (obi_wdata),
    .obi_rvalid (obi_rvalid),
    .obi_rdata  (obi_rdata)
  );

  obi_mem_slave u_mem (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (obi_req),
    .addr   (obi_addr),
    .we     (obi_we),
    .be     (obi_be),
    .wdata  (obi_wdata),
    .gnt    (obi_gnt),
    .rvalid (obi_rvalid),
    .rdata  (obi_rdata)
  );

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Initial memory word at a word-aligned byte address
  function automatic logic [31:0] fill_word(input logic [31:0] wa);
    fill_word = {wa[15:0] ^ 16'ha5c3, ~wa[15:0]};
  endfunction

  // Word addresses inside the protected region fault
  function automatic logic in_region(input logic [31:0] wa);
    logic [31:0] lo;
    logic [31:0] hi;
    lo        = `MPU_PROT_LO;
    hi        = `MPU_PROT_HI;
    in_region = (wa[31:2] >= lo[31:2]) && (wa[31:2] <= hi[31:2]);
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Predicts the bus parts, the memory effect and the response of one access
  task automatic model_access(input lsu_op_e o, input logic [31:0] a,
                              input logic [31:0] d);
    int          size;
    int          off;
    logic [31:0] word;
    logic [7:0]  lanes;
    logic [63:0] wd_wide;
    logic        spl;
    logic        f0;
    logic        f1;
    logic        st;
    logic        sent;
    logic [31:0] val;
    case (o)
      LB, LBU, SB: size = 1;
      LH, LHU, SH: size = 2;
      default:     size = 4;
    endcase
    off     = a[1:0];
    word    = {a[31:2], 2'b00};
    lanes   = 8'((1 << size) - 1) << off;
    wd_wide = {32'h0000_0000, d} << (8 * off);
    spl     = (off + size) > 4;
    st      = o inside {SB, SH, SW};
    f0      = in_region(word);
    f1      = spl && in_region(word + 32'd4);

    // A faulting first part also suppresses the second
    if (!f0) begin
      exp_addr.push_back(word);
      exp_we.push_back(st);
      exp_be.push_back(lanes[3:0]);
      exp_wdata.push_back(wd_wide[31:0]);
    end
    if (!f0 && spl && !f1) begin
      exp_addr.push_back(word + 32'd4);
      exp_we.push_back(st);
      exp_be.push_back(lanes[7:4]);
      exp_wdata.push_back(wd_wide[63:32]);
    end

    // Bytes of a part that reached the bus are written, the rest stay
    val = 32'h0000_0000;
    for (int i = 0; i < size; i++) begin
      sent = ((off + i) < 4) ? !f0 : (!f0 && !f1);
      if (st && sent) begin
        shadow[9'(a + i)] = d[8*i +: 8];
      end
      val[8*i +: 8] = shadow[9'(a + i)];
    end
    case (o)
      LB:      val = {{24{val[7]}}, val[7:0]};
      LH:      val = {{16{val[15]}}, val[15:0]};
      default: val = val;
    endcase
    exp_rdata.push_back((f0 || f1 || st) ? 32'h0000_0000 : val);
    exp_err.push_back(f0 || f1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Offers one access for one cycle once ready is seen high
  // Called and returning a few units after a rising edge
  task automatic offer(input lsu_op_e o, input logic [31:0] a, input logic [31:0] d,
                       input logic halt, input logic kill);
    while (!ready) begin
      @(posedge clk);
      #5;
    end
    valid   = 1'b1;
    op      = o;
    addr    = a;
    wdata   = d;
    halt_ex = halt;
    kill_ex = kill;
    if (!halt && !kill) begin
      model_access(o, a, d);
      accepted++;
    end
    @(posedge clk);
    #5;
    valid   = 1'b0;
    halt_ex = 1'b0;
    kill_ex = 1'b0;
    // A refused offer leaves the unit idle and ready
    if (halt || kill) begin
      check("ready", {31'h0, ready}, 32'h1);
    end else begin
      open_accesses++;
    end
  endtask

  initial begin
    lsu_op_e     o;
    logic [31:0] a;
    logic [31:0] d;
    void'($urandom(32'h7058127b));
    rst_n         = 1'b0;
    valid         = 1'b0;
    op            = LW;
    addr          = 32'h0000_0000;
    wdata         = 32'h0000_0000;
    halt_ex       = 1'b0;
    kill_ex       = 1'b0;
    accepted      = 0;
    open_accesses = 0;
    for (int b = 0; b < 512; b++) begin
      shadow[b] = fill_word(b & ~3) >> (8 * (b % 4));
    end

    // Outputs are quiet while reset is held
    @(negedge clk);
    check("ready", {31'h0, ready}, 32'h0);
    check("obi_req", {31'h0, obi_req}, 32'h0);
    check("resp_valid", {31'h0, resp_valid}, 32'h0);
    @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Store then load of the same aligned word
    offer(SW, 32'h40, 32'hcafe_f00d, 1'b0, 1'b0);
    offer(LW, 32'h40, 32'h0, 1'b0, 1'b0);
    // Narrow loads at every offset, halfword at offset 3 crosses
    for (int k = 0; k < 4; k++) begin
      for (int off = 0; off < 4; off++) begin
        offer(lsu_op_e'(k), 32'h40 + off, 32'h0, 1'b0, 1'b0);
      end
    end
    // Misaligned accesses across a word boundary
    offer(SW, 32'h46, 32'h1234_5678, 1'b0, 1'b0);
    offer(LW, 32'h46, 32'h0, 1'b0, 1'b0);
    offer(SH, 32'h4b, 32'h0000_9abc, 1'b0, 1'b0);
    offer(LH, 32'h4b, 32'h0, 1'b0, 1'b0);
    offer(LHU, 32'h4b, 32'h0, 1'b0, 1'b0);
    offer(LW, 32'h4d, 32'h0, 1'b0, 1'b0);
    // Protected region, first part and second part faulting
    offer(LW, 32'h100, 32'h0, 1'b0, 1'b0);
    offer(SW, 32'h0fe, 32'h5555_aaaa, 1'b0, 1'b0);
    offer(LW, 32'h0fc, 32'h0, 1'b0, 1'b0);
    offer(LW, 32'h13e, 32'h0, 1'b0, 1'b0);
    offer(SH, 32'h13f, 32'h0000_7777, 1'b0, 1'b0);
    offer(LW, 32'h140, 32'h0, 1'b0, 1'b0);
    offer(LH, 32'h0ff, 32'h0, 1'b0, 1'b0);
    offer(LW, 32'h13c, 32'h0, 1'b0, 1'b0);
    // Halted and killed offers of one store, then the load that shows no write
    offer(SW, 32'h80, 32'hdead_beef, 1'b1, 1'b0);
    offer(SW, 32'h80, 32'hdead_beef, 1'b0, 1'b1);
    offer(LW, 32'h80, 32'h0, 1'b0, 1'b0);

    // Random mix over 512 bytes, protected region included
    while (accepted < N_ACCESS) begin
      o = lsu_op_e'($urandom_range(0, 7));
      a = $urandom_range(0, 511);
      d = $urandom;
      if ($urandom_range(0, 19) == 0) begin
        offer(o, a, d, 1'b1, 1'b0);
        offer(o, a, d, 1'b0, 1'b1);
      end
      offer(o, a, d, 1'b0, 1'b0);
    end

    // Drain, then look for anything left over or arriving late
    while (exp_rdata.size() != 0 || busy) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (exp_addr.size() == 0 && exp_rdata.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Bus requests or responses were still expected when the run ended");
      stop_with_failure();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////////////

  // Ports are sampled mid-cycle, where the edge that follows will see them
  always @(negedge clk) begin : port_monitor
    logic [31:0] mask;
    logic        we_e;
    if (rst_n) begin
      if (obi_req && obi_gnt) begin
        if (exp_addr.size() == 0) begin
          $display("Bus request to address 0x%h granted with none expected", obi_addr);
          stop_with_failure();
        end
        we_e = exp_we.pop_front();
        mask = lane_mask(exp_be[0]);
        check("obi_addr", obi_addr, exp_addr.pop_front());
        check("obi_we", {31'h0, obi_we}, {31'h0, we_e});
        check("obi_be", {28'h0, obi_be}, {28'h0, exp_be.pop_front()});
        // Store data only matters on the enabled lanes
        if (we_e) begin
          check("obi_wdata", obi_wdata & mask, exp_wdata[0] & mask);
        end
        void'(exp_wdata.pop_front());
        in_flight++;
      end
      if (obi_rvalid) begin
        in_flight--;
      end
      if (in_flight > `LSU_DEPTH) begin
        $display("More than %0d bus requests granted without a response", `LSU_DEPTH);
        stop_with_failure();
      end
      if (resp_valid) begin
        if (exp_rdata.size() == 0) begin
          $display("Core response seen with no accepted access waiting for one");
          stop_with_failure();
        end
        check("resp_rdata", resp_rdata, exp_rdata.pop_front());
        check("resp_err", {31'h0, resp_err}, {31'h0, exp_err.pop_front()});
        open_accesses--;
      end
      // The unit stays busy from acceptance until the response goes out
      check("busy", {31'h0, busy}, {31'h0, open_accesses != 0});
    end
  end

  // Run length bound, scaled to the number of accesses
  initial begin
    cycles    = 0;
    in_flight = 0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the run hung and did not finish within %0d cycles", MAX_CYCLES);
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/lsu_pkg.sv
common/obi_pkg.sv
common/obi_if.sv
hw/lsu/lsu_mpu.sv
hw/lsu/lsu_req_split.sv
hw/lsu/lsu_resp_align.sv
hw/lsu/load_store_unit.sv
hw/lsu_subsys.sv
dv/obi_mem_slave.sv
dv/tb_lsu.sv

//--- hw/lsu/load_store_unit.sv
/*
  Data-side load/store unit. Accepts one access at a time from execute,
  drives it onto the data bus in one or two parts, counts bus transactions
  in flight and keeps a two-entry in-order queue that the response path
  drains. Faulting parts never reach the bus
*/
`default_nettype none

`include "lsu_macros.svh"

module load_store_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid,
  input  lsu_pkg::lsu_op_e   op,
  input  logic [31:0]        addr,
  input  logic [31:0]        wdata,
  input  lsu_pkg::ctrl_fsm_t ctrl_fsm,
  output logic               ready,
  output logic               busy,
  output logic               resp_valid,
  output logic [31:0]        resp_rdata,
  output logic               resp_err,
  obi_if.manager             bus
);
  import lsu_pkg::*;
  import obi_pkg::*;

  obi_req_t    payload;
  mpu_status_e mpu_status;
  logic        last;
  logic        split;
  logic        accept;
  logic        active_q;
  logic        active_d;
  logic        ready_q;
  logic        ready_d;
  logic        fault_wait_q;
  logic        fault_wait_d;
  logic [1:0]  cnt_q;
  logic [1:0]  cnt_d;
  logic        count_up;
  logic        count_down;
  logic        part_fault;
  logic        first_part;
  logic        split_now;
  logic        access_done;
  logic        advance;
  // Two-entry access queue, one slot per accepted access
  lsu_op_e     q_op [2];
  logic [1:0]  q_offset [2];
  logic        q_split [2];
  logic        q_fault [2];
  logic        q_wr_ptr;
  logic        q_rd_ptr;
  logic        cur_slot_q;
  logic [1:0]  q_cnt_q;
  logic [1:0]  q_cnt_d;
  logic        cur_at_head;
  logic        entry_split;
  logic        entry_fault;
  logic        entry_pop;

  ////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////

  // A killed or halted offer is simply not taken
  assign accept = valid && ready_q && !ctrl_fsm.halt_ex && !ctrl_fsm.kill_ex;

  lsu_req_split u_req_split (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (accept),
    .op      (op),
    .addr    (addr),
    .wdata   (wdata),
    .advance (advance),
    .payload (payload),
    .last    (last),
    .split   (split)
  );

  lsu_mpu u_mpu (
    .addr   (payload.addr),
    .status (mpu_status)
  );

  assign part_fault = active_q && (mpu_status == MPU_FAULT);
  assign first_part = !(split && last);
  // Split flag seen by the response path, set only if the first half went out
  assign split_now  = split && !(first_part && part_fault);

  // Counter only falls while req is up, so req cannot drop before gnt
  assign bus.req         = active_q && !part_fault && (cnt_q < 2'(`LSU_DEPTH));
  assign bus.req_payload = payload;

  assign count_up    = bus.req && bus.gnt;
  assign count_down  = bus.rvalid;
  // A fault ends the access at once, so a faulting first half skips the second
  assign access_done = part_fault || (count_up && last);
  assign advance     = count_up && !last;

  assign cnt_d   = cnt_q + {1'b0, count_up} - {1'b0, count_down};
  assign q_cnt_d = q_cnt_q + {1'b0, accept} - {1'b0, entry_pop};

  always_comb begin
    active_d = active_q;
    if (accept) begin
      active_d = 1'b1;
    end else if (access_done) begin
      active_d = 1'b0;
    end
  end

  // Ready stays low until a faulting access has answered
  assign fault_wait_d = (fault_wait_q || (access_done && part_fault)) &&
                        !(entry_pop && entry_fault);
  assign ready_d      = !active_d && !fault_wait_d && (cnt_d < 2'(`LSU_DEPTH)) &&
                        (q_cnt_d != 2'd2);

  assign ready = ready_q;
  assign busy  = (cnt_q != 2'd0) || active_q || (q_cnt_q != 2'd0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      ready_q      <= 1'b0;
      fault_wait_q <= 1'b0;
      cnt_q        <= 2'd0;
      q_cnt_q      <= 2'd0;
      q_wr_ptr     <= 1'b0;
      q_rd_ptr     <= 1'b0;
      cur_slot_q   <= 1'b0;
    end else begin
      active_q     <= active_d;
      ready_q      <= ready_d;
      fault_wait_q <= fault_wait_d;
      cnt_q        <= cnt_d;
      q_cnt_q      <= q_cnt_d;
      if (accept) begin
        q_wr_ptr   <= ~q_wr_ptr;
        cur_slot_q <= q_wr_ptr;
      end
      if (entry_pop) begin
        q_rd_ptr <= ~q_rd_ptr;
      end
    end
  end

  // Split and fault of a slot are final only once its access is done
  always_ff @(posedge clk) begin
    if (accept) begin
      q_op[q_wr_ptr]     <= op;
      q_offset[q_wr_ptr] <= addr[1:0];
    end
    if (access_done) begin
      q_split[cur_slot_q] <= split_now;
      q_fault[cur_slot_q] <= part_fault;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////

  // While the access at the head is still on the bus its flags come live
  assign cur_at_head = active_q && (cur_slot_q == q_rd_ptr);
  assign entry_split = cur_at_head ? split_now : q_split[q_rd_ptr];
  assign entry_fault = cur_at_head ? part_fault : q_fault[q_rd_ptr];

  lsu_resp_align u_resp_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .rvalid       (bus.rvalid),
    .rdata        (bus.rsp_payload.rdata),
    .entry_valid  (q_cnt_q != 2'd0),
    .entry_op     (q_op[q_rd_ptr]),
    .entry_offset (q_offset[q_rd_ptr]),
    .entry_split  (entry_split),
    .entry_fault  (entry_fault),
    .entry_pop    (entry_pop),
    .resp_valid   (resp_valid),
    .resp_rdata   (resp_rdata),
    .resp_err     (resp_err)
  );

  ////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////

  a_cnt_bound : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= 2'(`LSU_DEPTH));

  a_cnt_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q == 2'(`LSU_DEPTH)) |-> (!count_up || count_down));

  a_cnt_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q == 2'd0) |=> (cnt_q <= 2'd1));

  a_busy_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q != 2'd0) |-> busy);

  // The memory side must not answer what was never granted
  a_no_spurious_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    bus.rvalid |-> (cnt_q != 2'd0));

  a_addr_phase_defined : assert property (@(posedge clk) disable iff (!rst_n)
    bus.req |-> !$isunknown({bus.req_payload.addr, bus.req_payload.we, bus.req_payload.be}));

  // A halted or killed cycle adds nothing to the access queue
  a_halt_kill_no_push : assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl_fsm.halt_ex || ctrl_fsm.kill_ex) |=> (q_cnt_q <= $past(q_cnt_q)));

endmodule

`default_nettype wire

//--- hw/lsu/lsu_mpu.sv
/*
  Data-side protection check. Classifies a bus-level address against one
  fixed word-granular region and flags every word inside it as faulting.
  Purely combinational so the fault is known in the request cycle
*/
`default_nettype none

`include "lsu_macros.svh"

module lsu_mpu (
  input  logic [`LSU_ADDR_W-1:0] addr,
  output lsu_pkg::mpu_status_e   status
);
  import lsu_pkg::*;

  // Region bounds widened to the address width
  localparam logic [`LSU_ADDR_W-1:0] PROT_LO = `MPU_PROT_LO;
  localparam logic [`LSU_ADDR_W-1:0] PROT_HI = `MPU_PROT_HI;

  logic [`LSU_ADDR_W-3:0] word_addr;
  logic                   above_lo;
  logic                   below_hi;

  // Bus addresses are word aligned so the low bits carry no information
  assign word_addr = addr[`LSU_ADDR_W-1:2];

  // Both bounds are inclusive
  assign above_lo = (word_addr >= PROT_LO[`LSU_ADDR_W-1:2]);
  assign below_hi = (word_addr <= PROT_HI[`LSU_ADDR_W-1:2]);

  // A word inside the region is closed to loads and stores alike
  assign status = (above_lo && below_hi) ? MPU_FAULT : MPU_OK;

endmodule

`default_nettype wire

//--- hw/lsu/lsu_req_split.sv
/*
  Request splitter. Latches an accepted access and turns it into one or
  two word-aligned bus requests with byte enables and store data moved
  onto the right byte lanes. A second part exists only when the access
  runs past the end of its word
*/
`default_nettype none

module lsu_req_split (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  lsu_pkg::lsu_op_e  op,
  input  logic [31:0]       addr,
  input  logic [31:0]       wdata,
  input  logic              advance,
  output obi_pkg::obi_req_t payload,
  output logic              last,
  output logic              split
);
  import lsu_pkg::*;

  // Which word of a crossing access is on the bus
  typedef enum logic {
    FIRST,
    SECOND
  } split_state_e;

  split_state_e state_q;
  lsu_op_e      op_q;
  logic [31:0]  addr_q;
  logic [31:0]  wdata_q;
  logic [3:0]   size_mask;
  logic [7:0]   be_wide;
  logic [63:0]  wdata_wide;
  logic [31:0]  word_addr;

  // A new access always begins with its first word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FIRST;
    end else if (start) begin
      state_q <= FIRST;
    end else if (advance) begin
      state_q <= SECOND;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q    <= op;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // Byte lanes used by the access before it is shifted to its offset
  always_comb begin
    case (op_q)
      LB, LBU, SB: size_mask = 4'b0001;
      LH, LHU, SH: size_mask = 4'b0011;
      default:     size_mask = 4'b1111;
    endcase
  end

  // Lanes and data over two words, upper half belongs to the next word
  assign be_wide    = {4'b0000, size_mask} << addr_q[1:0];
  assign wdata_wide = {32'h0000_0000, wdata_q} << {addr_q[1:0], 3'b000};
  assign word_addr  = {addr_q[31:2], 2'b00};

  assign split = |be_wide[7:4];
  assign last  = !split || (state_q == SECOND);

  always_comb begin
    payload.we = op_q inside {SB, SH, SW};
    if (state_q == SECOND) begin
      // Remaining bytes sit at the bottom of the following word
      payload.addr  = word_addr + 32'd4;
      payload.be    = be_wide[7:4];
      payload.wdata = wdata_wide[63:32];
    end else begin
      payload.addr  = word_addr;
      payload.be    = be_wide[3:0];
      payload.wdata = wdata_wide[31:0];
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu/lsu_resp_align.sv
/*
  Response path of the load/store unit. Works on the head of the in-order
  access queue, collects one or two bus beats, merges them by byte offset
  and sign- or zero-extends the result. Stores answer with zero data and
  faulting accesses with an error and zero data
*/
`default_nettype none

module lsu_resp_align (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rvalid,
  input  logic [31:0]      rdata,
  input  logic             entry_valid,
  input  lsu_pkg::lsu_op_e entry_op,
  input  logic [1:0]       entry_offset,
  input  logic             entry_split,
  input  logic             entry_fault,
  output logic             entry_pop,
  output logic             resp_valid,
  output logic [31:0]      resp_rdata,
  output logic             resp_err
);
  import lsu_pkg::*;

  logic        have_first_q;
  logic [31:0] first_q;
  logic        fire;
  logic        stash;
  logic        is_load;
  logic [63:0] merged;
  logic [63:0] shifted;
  logic [31:0] load_data;

  // A faulting entry with split set still owes the beat of its first half
  always_comb begin
    if (entry_fault) begin
      fire = entry_valid && (!entry_split || have_first_q || rvalid);
    end else if (entry_split) begin
      fire = entry_valid && have_first_q && rvalid;
    end else begin
      fire = entry_valid && rvalid;
    end
  end

  // First beat of a clean split access waits here for the second
  assign stash     = entry_valid && rvalid && entry_split && !entry_fault && !have_first_q;
  assign entry_pop = fire;
  assign is_load   = entry_op inside {LB, LBU, LH, LHU, LW};

  // Lower word first, then drop the bytes below the access offset
  assign merged  = entry_split ? {rdata, first_q} : {32'h0000_0000, rdata};
  assign shifted = merged >> {entry_offset, 3'b000};

  always_comb begin
    case (entry_op)
      LB:      load_data = {{24{shifted[7]}}, shifted[7:0]};
      LBU:     load_data = {24'h00_0000, shifted[7:0]};
      LH:      load_data = {{16{shifted[15]}}, shifted[15:0]};
      LHU:     load_data = {16'h0000, shifted[15:0]};
      default: load_data = shifted[31:0];
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      have_first_q <= 1'b0;
      resp_valid   <= 1'b0;
      resp_err     <= 1'b0;
    end else begin
      resp_valid <= fire;
      if (fire) begin
        resp_err     <= entry_fault;
        have_first_q <= 1'b0;
      end else if (stash) begin
        have_first_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stash) begin
      first_q <= rdata;
    end
    if (fire) begin
      resp_rdata <= (entry_fault || !is_load) ? 32'h0000_0000 : load_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_subsys.sv
/*
  Load/store subsystem top. Connects the load/store unit to plain data bus
  ports through the bus bundle and packs the execute-stage controls
*/
`default_nettype none

module lsu_subsys (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid,
  input  lsu_pkg::lsu_op_e op,
  input  logic [31:0]      addr,
  input  logic [31:0]      wdata,
  input  logic             halt_ex,
  input  logic             kill_ex,
  output logic             ready,
  output logic             busy,
  output logic             resp_valid,
  output logic [31:0]      resp_rdata,
  output logic             resp_err,
  output logic             obi_req,
  input  logic             obi_gnt,
  output logic [31:0]      obi_addr,
  output logic             obi_we,
  output logic [3:0]       obi_be,
  output logic [31:0]      obi_wdata,
  input  logic             obi_rvalid,
  input  logic [31:0]      obi_rdata
);
  import lsu_pkg::*;

  ctrl_fsm_t ctrl_fsm;

  obi_if bus_if ();

  assign ctrl_fsm.halt_ex = halt_ex;
  assign ctrl_fsm.kill_ex = kill_ex;

  // Address phase out to the memory side
  assign obi_req   = bus_if.req;
  assign obi_addr  = bus_if.req_payload.addr;
  assign obi_we    = bus_if.req_payload.we;
  assign obi_be    = bus_if.req_payload.be;
  assign obi_wdata = bus_if.req_payload.wdata;

  // Grant and response back from it
  assign bus_if.gnt               = obi_gnt;
  assign bus_if.rvalid            = obi_rvalid;
  assign bus_if.rsp_payload.rdata = obi_rdata;

  load_store_unit u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid      (valid),
    .op         (op),
    .addr       (addr),
    .wdata      (wdata),
    .ctrl_fsm   (ctrl_fsm),
    .ready      (ready),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .bus        (bus_if.manager)
  );

endmodule

`default_nettype wire
